/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_caster
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --timescale 1ns/1ps -j 0

SOURCES := $(wildcard source/*.sv testbench/*.sv testbench/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^Test passed$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
+incdir+testbench
source/caster_pkg.sv
source/scan_timing.sv
source/dither_y4.sv
source/pixel_update.sv
source/epd_drive.sv
source/caster.sv
testbench/tb_caster.sv

/* source/caster.sv */
`timescale 1ns/1ps

module caster
    import caster_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        sys_ready,
    input  logic        vin_vsync,
    input  y4_quad_t    vin_pixel,
    output logic        vin_ready,
    output logic        b_trigger,
    input  state_quad_t bi_pixel,
    output logic        bi_ready,
    output state_quad_t bo_pixel,
    output logic        bo_valid,
    output logic        epd_gdoe,
    output logic        epd_gdclk,
    output logic        epd_gdsp,
    output logic        epd_sdoe,
    output logic        epd_sdle,
    output logic        epd_sdce0,
    output logic        epd_sdclk,
    output logic [7:0]  epd_sd
);

    logic scan_running;
    logic in_vfp;
    logic in_vsync;
    logic in_vbp;
    logic in_vact;
    logic in_hfp;
    logic in_hsync;
    logic in_hbp;
    logic in_hact;
    logic fetch;
    logic [1:0] dither_row;
    op_state_e op_state;
    cnt_t op_frame;
    logic [3:0] mono;
    logic [7:0] drive;
    state_quad_t state_out;

    // Video and framebuffer are read on the same strobe
    assign vin_ready = fetch;
    assign bi_ready = fetch;

    scan_timing scan_timing_i (
        .clk          (clk),
        .rst          (rst),
        .sys_ready    (sys_ready),
        .vin_vsync    (vin_vsync),
        .scan_running (scan_running),
        .in_vfp       (in_vfp),
        .in_vsync     (in_vsync),
        .in_vbp       (in_vbp),
        .in_vact      (in_vact),
        .in_hfp       (in_hfp),
        .in_hsync     (in_hsync),
        .in_hbp       (in_hbp),
        .in_hact      (in_hact),
        .fetch        (fetch),
        .b_trigger    (b_trigger),
        .dither_row   (dither_row),
        .op_state     (op_state),
        .op_frame     (op_frame)
    );

    dither_y4 dither_y4_i (
        .clk    (clk),
        .rst    (rst),
        .pix_in (vin_pixel),
        .row    (dither_row),
        .mono   (mono)
    );

    pixel_update pixel_update_i (
        .clk       (clk),
        .rst       (rst),
        .mono      (mono),
        .state_in  (bi_pixel),
        .op_state  (op_state),
        .op_frame  (op_frame),
        .drive     (drive),
        .state_out (state_out)
    );

    epd_drive epd_drive_i (
        .clk          (clk),
        .rst          (rst),
        .scan_running (scan_running),
        .in_vfp       (in_vfp),
        .in_vsync     (in_vsync),
        .in_vbp       (in_vbp),
        .in_vact      (in_vact),
        .in_hfp       (in_hfp),
        .in_hsync     (in_hsync),
        .in_hbp       (in_hbp),
        .in_hact      (in_hact),
        .drive        (drive),
        .state_out    (state_out),
        .epd_gdoe     (epd_gdoe),
        .epd_gdclk    (epd_gdclk),
        .epd_gdsp     (epd_gdsp),
        .epd_sdoe     (epd_sdoe),
        .epd_sdle     (epd_sdle),
        .epd_sdce0    (epd_sdce0),
        .epd_sdclk    (epd_sdclk),
        .epd_sd       (epd_sd),
        .bo_pixel     (bo_pixel),
        .bo_valid     (bo_valid)
    );

endmodule

/* source/caster_pkg.sv */
package caster_pkg;

    //////////////////////////////////////////////////
    // Scan timing, small values for simulation
    //////////////////////////////////////////////////

    // Vertical regions in lines
    localparam int V_FP = 3;
    localparam int V_SYNC = 1;
    localparam int V_BP = 2;
    localparam int V_ACT = 8;
    localparam int V_TOTAL = V_FP + V_SYNC + V_BP + V_ACT;

    // Horizontal regions in clocks, four pixels per clock
    localparam int H_FP = 1;
    localparam int H_SYNC = 1;
    localparam int H_BP = 2;
    localparam int H_ACT = 6;
    localparam int H_TOTAL = H_FP + H_SYNC + H_BP + H_ACT;

    localparam int VS_DELAY = 8;
    localparam int PIPE_LEAD = 2;

    // Operation sequence
    localparam int INIT_FRAMES = 2;
    localparam int UPDATE_FRAMES = 3;

    typedef logic [10:0] cnt_t;
    typedef logic [15:0] y4_quad_t;
    typedef logic [15:0] state_t;
    typedef logic [63:0] state_quad_t;
    typedef logic [1:0] drive_t;

    // 4x4 ordered dither thresholds, row major
    localparam logic [3:0] BAYER [16] = '{
        4'd0,  4'd8,  4'd2,  4'd10,
        4'd12, 4'd4,  4'd14, 4'd6,
        4'd3,  4'd11, 4'd1,  4'd9,
        4'd15, 4'd7,  4'd13, 4'd5
    };

    // Source driver codes per pixel
    localparam drive_t DRV_NONE = 2'b00;
    localparam drive_t DRV_BLACK = 2'b01;
    localparam drive_t DRV_WHITE = 2'b10;

    typedef enum logic [1:0] {SCAN_IDLE, SCAN_WAITING, SCAN_RUNNING} scan_state_e;
    typedef enum logic {OP_INIT, OP_NORMAL} op_state_e;

endpackage

/* source/dither_y4.sv */
`timescale 1ns/1ps

module dither_y4
    import caster_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  y4_quad_t   pix_in,
    input  logic [1:0] row,
    output logic [3:0] mono
);

    logic [3:0] mono_next;

    //////////////////////////////////////////////////
    // Threshold compare per lane
    //////////////////////////////////////////////////

    // Groups of four keep lane i in dither column i
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            mono_next[i] = pix_in[i*4 +: 4] > BAYER[{row, 2'(i)}];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mono <= '0;
        end else begin
            mono <= mono_next;
        end
    end

endmodule

/* source/epd_drive.sv */
`timescale 1ns/1ps

module epd_drive
    import caster_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        scan_running,
    input  logic        in_vfp,
    input  logic        in_vsync,
    input  logic        in_vbp,
    input  logic        in_vact,
    input  logic        in_hfp,
    input  logic        in_hsync,
    input  logic        in_hbp,
    input  logic        in_hact,
    input  logic [7:0]  drive,
    input  state_quad_t state_out,
    output logic        epd_gdoe,
    output logic        epd_gdclk,
    output logic        epd_gdsp,
    output logic        epd_sdoe,
    output logic        epd_sdle,
    output logic        epd_sdce0,
    output logic        epd_sdclk,
    output logic [7:0]  epd_sd,
    output state_quad_t bo_pixel,
    output logic        bo_valid
);

    logic in_act;
    logic gdclk_next;

    assign in_act = in_vact && in_hact;

    //////////////////////////////////////////////////
    // Gate driver
    //////////////////////////////////////////////////

    // Enabled on every line past the front porch
    assign epd_gdoe = scan_running && !in_vfp;
    assign epd_gdsp = !in_vsync;

    // Gate clock lags its region by one clock
    assign gdclk_next = in_hsync || in_hbp || in_hact;

    always_ff @(posedge clk) begin
        if (rst) begin
            epd_gdclk <= 1'b0;
        end else begin
            epd_gdclk <= gdclk_next;
        end
    end

    //////////////////////////////////////////////////
    // Source driver
    //////////////////////////////////////////////////

    assign epd_sdoe = in_vsync || in_vbp || in_vact;
    assign epd_sdle = in_hsync;
    assign epd_sdce0 = !in_act;

    // Source clock idles low through back porch
    assign epd_sdclk = (in_hfp || in_hsync || in_hact) ? ~clk : 1'b0;

    assign epd_sd = in_act ? drive : 8'h00;

    // Framebuffer write-back shares the active window
    assign bo_pixel = state_out;
    assign bo_valid = in_act;

endmodule

/* source/pixel_update.sv */
`timescale 1ns/1ps

module pixel_update
    import caster_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [3:0]  mono,
    input  state_quad_t state_in,
    input  op_state_e   op_state,
    input  cnt_t        op_frame,
    output logic [7:0]  drive,
    output state_quad_t state_out
);

    state_quad_t state_q;
    state_quad_t state_next;
    logic [7:0] drive_next;

    // Line up the framebuffer word with the dithered pixel
    always_ff @(posedge clk) begin
        state_q <= state_in;
    end

    //////////////////////////////////////////////////
    // Waveform step per lane
    //////////////////////////////////////////////////

    always_comb begin : lane_step
        state_t cur;
        state_t nxt;
        drive_t drv;
        logic level;
        logic [7:0] remain;

        for (int i = 0; i < 4; i++) begin
            cur = state_q[i*16 +: 16];
            level = cur[15];
            remain = cur[7:0];
            if (op_state == OP_INIT) begin
                // Alternate full black and full white frames
                drv = op_frame[0] ? DRV_WHITE : DRV_BLACK;
                nxt = '0;
            end else if (remain != 8'd0) begin
                // Transition still in progress
                drv = level ? DRV_WHITE : DRV_BLACK;
                nxt = {level, 7'd0, remain - 8'd1};
            end else if (mono[i] != level) begin
                drv = mono[i] ? DRV_WHITE : DRV_BLACK;
                nxt = {mono[i], 7'd0, 8'(UPDATE_FRAMES - 1)};
            end else begin
                drv = DRV_NONE;
                nxt = cur;
            end
            drive_next[i*2 +: 2] = drv;
            state_next[i*16 +: 16] = nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            drive <= '0;
        end else begin
            drive <= drive_next;
        end
    end

    always_ff @(posedge clk) begin
        state_out <= state_next;
    end

endmodule

/* source/scan_timing.sv */
`timescale 1ns/1ps

module scan_timing
    import caster_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       sys_ready,
    input  logic       vin_vsync,
    output logic       scan_running,
    output logic       in_vfp,
    output logic       in_vsync,
    output logic       in_vbp,
    output logic       in_vact,
    output logic       in_hfp,
    output logic       in_hsync,
    output logic       in_hbp,
    output logic       in_hact,
    output logic       fetch,
    output logic       b_trigger,
    output logic [1:0] dither_row,
    output op_state_e  op_state,
    output cnt_t       op_frame
);

    scan_state_e scan_state;
    cnt_t h_cnt;
    cnt_t v_cnt;
    cnt_t act_line;
    logic line_end;
    logic frame_end;

    assign scan_running = (scan_state == SCAN_RUNNING);
    assign line_end = scan_running && (h_cnt == cnt_t'(H_TOTAL - 1));
    assign frame_end = line_end && (v_cnt == cnt_t'(V_TOTAL - 1));

    //////////////////////////////////////////////////
    // Scan state machine
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            scan_state <= SCAN_IDLE;
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            case (scan_state)
                SCAN_IDLE: begin
                    h_cnt <= '0;
                    v_cnt <= '0;
                    if (sys_ready && vin_vsync) begin
                        scan_state <= SCAN_WAITING;
                    end
                end
                SCAN_WAITING: begin
                    // Column counter doubles as the delay counter here
                    if (h_cnt == cnt_t'(VS_DELAY)) begin
                        scan_state <= SCAN_RUNNING;
                        h_cnt <= '0;
                    end else begin
                        h_cnt <= h_cnt + 1'b1;
                    end
                end
                SCAN_RUNNING: begin
                    if (frame_end) begin
                        scan_state <= SCAN_IDLE;
                        h_cnt <= '0;
                        v_cnt <= '0;
                    end else if (line_end) begin
                        h_cnt <= '0;
                        v_cnt <= v_cnt + 1'b1;
                    end else begin
                        h_cnt <= h_cnt + 1'b1;
                    end
                end
                default: begin
                    scan_state <= SCAN_IDLE;
                end
            endcase
        end
    end

    // Operation sequence, advanced once per frame
    always_ff @(posedge clk) begin
        if (rst) begin
            op_state <= OP_INIT;
            op_frame <= '0;
        end else if (frame_end) begin
            if (op_state == OP_INIT && op_frame == cnt_t'(INIT_FRAMES - 1)) begin
                op_state <= OP_NORMAL;
                op_frame <= '0;
            end else begin
                op_frame <= op_frame + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Region decode
    //////////////////////////////////////////////////

    assign in_vfp = scan_running && (v_cnt < cnt_t'(V_FP));
    assign in_vsync = scan_running && (v_cnt >= cnt_t'(V_FP))
        && (v_cnt < cnt_t'(V_FP + V_SYNC));
    assign in_vbp = scan_running && (v_cnt >= cnt_t'(V_FP + V_SYNC))
        && (v_cnt < cnt_t'(V_FP + V_SYNC + V_BP));
    assign in_vact = scan_running && (v_cnt >= cnt_t'(V_FP + V_SYNC + V_BP));

    assign in_hfp = scan_running && (h_cnt < cnt_t'(H_FP));
    assign in_hsync = scan_running && (h_cnt >= cnt_t'(H_FP))
        && (h_cnt < cnt_t'(H_FP + H_SYNC));
    assign in_hbp = scan_running && (h_cnt >= cnt_t'(H_FP + H_SYNC))
        && (h_cnt < cnt_t'(H_FP + H_SYNC + H_BP));
    assign in_hact = scan_running && (h_cnt >= cnt_t'(H_FP + H_SYNC + H_BP));

    // Same window as active columns, shifted early by the pipeline depth
    assign fetch = in_vact
        && (h_cnt >= cnt_t'(H_FP + H_SYNC + H_BP - PIPE_LEAD))
        && (h_cnt <= cnt_t'(H_TOTAL - 1 - PIPE_LEAD));

    assign act_line = v_cnt - cnt_t'(V_FP + V_SYNC + V_BP);
    assign dither_row = act_line[1:0];

    assign b_trigger = (scan_state == SCAN_WAITING);

endmodule

/* testbench/caster_model.svh */
`ifndef CASTER_MODEL_SVH
`define CASTER_MODEL_SVH

//////////////////////////////////////////////////
// Reference model of the scan and pixel path
//////////////////////////////////////////////////

// Region codes for both lines and columns
localparam int REG_FP = 0;
localparam int REG_SYNC = 1;
localparam int REG_BP = 2;
localparam int REG_ACT = 3;
localparam int REG_NONE = 4;

// Position inside a line or a frame, mapped to its region
function automatic int region_of(input int idx, input int fp, input int sync, input int bp);
    if (idx < fp) return REG_FP;
    if (idx < fp + sync) return REG_SYNC;
    if (idx < fp + sync + bp) return REG_BP;
    return REG_ACT;
endfunction

// Lane i sits in dither column i
function automatic logic [3:0] dither_mono(input y4_quad_t pix, input logic [1:0] row);
    logic [3:0] mono;
    for (int i = 0; i < 4; i++) begin
        mono[i] = pix[4*i +: 4] > BAYER[4*row + i];
    end
    return mono;
endfunction

// Drive code in bits 17..16, next state word below
function automatic logic [17:0] step_lane(input logic target, input state_t cur);
    logic level;
    logic [7:0] left;
    level = cur[15];
    left = cur[7:0];
    if (left != 8'd0) begin
        return {(level ? DRV_WHITE : DRV_BLACK), level, 7'd0, left - 8'd1};
    end
    if (target != level) begin
        return {(target ? DRV_WHITE : DRV_BLACK), target, 7'd0, 8'(UPDATE_FRAMES - 1)};
    end
    return {DRV_NONE, cur};
endfunction

`endif

/* testbench/tb_caster.sv */
`timescale 1ns/1ps

module tb_caster
    import caster_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 5;
    localparam int DRIVE_DELAY = 1;
    localparam int SAMPLE_DELAY = 75;
    localparam int NUM_FRAMES = 4;
    localparam int RUN_CYCLES = V_TOTAL * H_TOTAL;
    localparam int TIMEOUT_CYCLES = 4 * (VS_DELAY + 1 + RUN_CYCLES + 20);

    `include "caster_model.svh"

    typedef struct packed {
        y4_quad_t pix;
        state_quad_t st;
        logic [1:0] row;
        logic init;
        cnt_t frame;
    } entry_t;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic sys_ready = 1'b0;
    logic vin_vsync = 1'b0;
    y4_quad_t vin_pixel = '0;
    state_quad_t bi_pixel = '0;
    logic vin_ready, b_trigger, bi_ready, bo_valid;
    state_quad_t bo_pixel;
    logic epd_gdoe, epd_gdclk, epd_gdsp, epd_sdoe, epd_sdle, epd_sdce0, epd_sdclk;
    logic [7:0] epd_sd;

    int seed = 32'h784eae5c;
    int cycles = 0;
    int error_count = 0;
    int check_count = 0;
    int errors_at_start = 0;
    int tests_run = 0;
    int tests_bad = 0;
    int trig_starts = 0;
    int trig_len = 0;
    logic trig_prev = 1'b0;
    int run_idx = -1;
    int frames_done = 0;
    int valid_total = 0;
    int fetch_total = 0;
    int line_valid = 0;
    logic gdclk_exp = 1'b0;
    entry_t pending[$];

    caster caster_i (
        .clk(clk), .rst(rst), .sys_ready(sys_ready), .vin_vsync(vin_vsync),
        .vin_pixel(vin_pixel), .vin_ready(vin_ready), .b_trigger(b_trigger),
        .bi_pixel(bi_pixel), .bi_ready(bi_ready), .bo_pixel(bo_pixel), .bo_valid(bo_valid),
        .epd_gdoe(epd_gdoe), .epd_gdclk(epd_gdclk), .epd_gdsp(epd_gdsp),
        .epd_sdoe(epd_sdoe), .epd_sdle(epd_sdle), .epd_sdce0(epd_sdce0),
        .epd_sdclk(epd_sdclk), .epd_sd(epd_sd)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_equal(input logic [63:0] got, input logic [63:0] expected,
                               input string what);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, expected);
        end
    endtask

    task automatic start_test();
        errors_at_start = error_count;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (error_count != errors_at_start) tests_bad++;
        $display("[%0t] %s: %0d errors", $time, name, error_count - errors_at_start);
    endtask

    // Bit 15 random and frames remaining below UPDATE_FRAMES
    function automatic state_quad_t random_state_quad();
        state_quad_t q;
        logic [31:0] r;
        q = '0;
        for (int i = 0; i < 4; i++) begin
            r = $random(seed);
            q[16*i + 15] = r[31];
            q[16*i +: 8] = 8'(r[15:0] % UPDATE_FRAMES);
        end
        return q;
    endfunction

    always @(posedge clk) begin : pixel_source
        logic [31:0] r;
        #DRIVE_DELAY;
        r = $random(seed);
        vin_pixel = r[15:0];
        bi_pixel = random_state_quad();
    end

    task automatic close_frame();
        check_equal(64'(valid_total), 64'(V_ACT * H_ACT), "bo_valid count per frame");
        check_equal(64'(fetch_total), 64'(valid_total), "vin_ready count per frame");
        check_equal(64'(pending.size()), 64'd0, "inputs left without write-back");
        pending.delete();
        frames_done++;
    endtask

    //////////////////////////////////////////////////
    // Output monitor sampled while the clock is low
    //////////////////////////////////////////////////

    always begin : monitor
        int line_idx;
        int col_idx;
        int lreg;
        int creg;
        logic act;
        logic fetch_exp;
        entry_t e;
        logic [3:0] mono;
        logic [17:0] lane;
        logic [7:0] exp_sd;
        state_quad_t exp_bo;

        @(posedge clk);
        #SAMPLE_DELAY;
        if (!rst) begin
            // Frame phase follows b_trigger
            if (b_trigger) begin
                if (!trig_prev) begin
                    trig_starts++;
                    trig_len = 0;
                    valid_total = 0;
                    fetch_total = 0;
                    line_valid = 0;
                end
                trig_len++;
            end else if (trig_prev) begin
                check_equal(64'(trig_len), 64'(VS_DELAY + 1), "b_trigger length");
                run_idx = 0;
            end else if (run_idx >= 0) begin
                run_idx++;
                if (run_idx == RUN_CYCLES) begin
                    run_idx = -1;
                    close_frame();
                end
            end
            trig_prev = b_trigger;

            line_idx = 0;
            col_idx = 0;
            lreg = REG_NONE;
            creg = REG_NONE;
            if (run_idx >= 0) begin
                line_idx = run_idx / H_TOTAL;
                col_idx = run_idx % H_TOTAL;
                lreg = region_of(line_idx, V_FP, V_SYNC, V_BP);
                creg = region_of(col_idx, H_FP, H_SYNC, H_BP);
            end
            act = (lreg == REG_ACT) && (creg == REG_ACT);
            fetch_exp = (lreg == REG_ACT) && (col_idx >= H_FP + H_SYNC + H_BP - PIPE_LEAD)
                && (col_idx <= H_TOTAL - 1 - PIPE_LEAD);

            check_equal(64'(epd_gdsp), 64'(lreg != REG_SYNC), "epd_gdsp");
            check_equal(64'(epd_gdoe), 64'(lreg < REG_NONE && lreg != REG_FP), "epd_gdoe");
            check_equal(64'(epd_sdoe), 64'(lreg < REG_NONE && lreg != REG_FP), "epd_sdoe");
            check_equal(64'(epd_sdle), 64'(creg == REG_SYNC), "epd_sdle");
            check_equal(64'(epd_sdclk), 64'(creg < REG_NONE && creg != REG_BP), "epd_sdclk");
            check_equal(64'(epd_gdclk), 64'(gdclk_exp), "epd_gdclk");
            gdclk_exp = (creg == REG_SYNC) || (creg == REG_BP) || (creg == REG_ACT);
            check_equal(64'(epd_sdce0), 64'(!act), "epd_sdce0");
            check_equal(64'(bo_valid), 64'(act), "bo_valid");
            check_equal(64'(vin_ready), 64'(fetch_exp), "vin_ready");
            check_equal(64'(bi_ready), 64'(fetch_exp), "bi_ready");
            if (!act) check_equal(64'(epd_sd), 64'd0, "epd_sd outside active window");

            if (vin_ready) begin
                e.pix = vin_pixel;
                e.st = bi_pixel;
                e.row = 2'((line_idx - (V_FP + V_SYNC + V_BP)) % 4);
                e.init = (trig_starts - 1) < INIT_FRAMES;
                e.frame = cnt_t'(trig_starts - 1);
                pending.push_back(e);
                fetch_total++;
            end

            if (bo_valid) begin
                valid_total++;
                line_valid++;
                if (pending.size() == 0) begin
                    error_count++;
                    $display("Write-back at %0t arrived with no pending input", $time);
                end else begin
                    e = pending.pop_front();
                    if (e.init) begin
                        // Alternate full black and full white frames
                        exp_sd = e.frame[0] ? {4{DRV_WHITE}} : {4{DRV_BLACK}};
                        exp_bo = '0;
                    end else begin
                        mono = dither_mono(e.pix, e.row);
                        for (int i = 0; i < 4; i++) begin
                            lane = step_lane(mono[i], e.st[16*i +: 16]);
                            exp_sd[2*i +: 2] = lane[17:16];
                            exp_bo[16*i +: 16] = lane[15:0];
                        end
                    end
                    check_equal(64'(epd_sd), 64'(exp_sd), "epd_sd drive codes");
                    check_equal(bo_pixel, exp_bo, "bo_pixel write-back");
                end
            end

            if (lreg == REG_ACT && col_idx == H_TOTAL - 1) begin
                check_equal(64'(line_valid), 64'(H_ACT), "bo_valid count per line");
                line_valid = 0;
            end
        end
    end

    // Source clock is the inverted clock, so it reads low while clk is high
    always @(posedge clk) begin : sdclk_high_phase
        #(CLK_PERIOD / 4);
        if (!rst) begin
            check_equal(64'(epd_sdclk), 64'd0, "epd_sdclk while clk high");
        end
    end

    always @(posedge clk) begin : watchdog
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the frames did not complete", cycles);
            $display("Test failed");
            $finish;
        end
    end

    task automatic pulse_vsync();
        @(posedge clk);
        #DRIVE_DELAY;
        vin_vsync = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        vin_vsync = 1'b0;
    endtask

    initial begin : main
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        start_test();
        repeat (3) @(posedge clk);
        check_equal(64'(trig_starts), 64'd0, "b_trigger rose after reset");
        end_test("reset levels");

        // Sync alone must not start a frame
        start_test();
        pulse_vsync();
        repeat (4) @(posedge clk);
        check_equal(64'(trig_starts), 64'd0, "b_trigger rose without sys_ready");
        end_test("vsync without sys_ready");

        @(posedge clk);
        #DRIVE_DELAY;
        sys_ready = 1'b1;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            start_test();
            pulse_vsync();
            while (frames_done < f + 1) @(posedge clk);
            end_test($sformatf("frame %0d", f));
        end

        $display("Tests %0d, with errors %0d, checks %0d, errors %0d",
                 tests_run, tests_bad, check_count, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
